// ==== verilog/mvu_pkg.sv ====
// ======================================================================
// MVU shared definitions
// ======================================================================
`default_nettype none

package mvu_pkg;

    localparam int N_LANES        = 8;      // Lanes per word
    localparam int B_ELEM         = 4;      // Signed element width
    localparam int B_WORD         = 32;     // Memory and APB word width
    localparam int B_ACC          = 32;     // Row accumulator width
    localparam int B_MEMA         = 8;      // Memory word address width
    localparam int B_LEN          = 8;      // Loop length width
    localparam int B_MSBIDX       = 5;      // Quantizer MSB index width
    localparam int B_PADDR        = 12;     // APB address width
    localparam int MEM_RD_LATENCY = 1;      // Registered memory read

    // APB register map, byte offsets
    localparam logic [B_PADDR-1:0] REG_CTRL    = 12'h000;  // start, irq enable
    localparam logic [B_PADDR-1:0] REG_STATUS  = 12'h004;  // busy, done, irq pending
    localparam logic [B_PADDR-1:0] REG_IBASE   = 12'h008;
    localparam logic [B_PADDR-1:0] REG_WBASE   = 12'h00C;
    localparam logic [B_PADDR-1:0] REG_OBASE   = 12'h010;
    localparam logic [B_PADDR-1:0] REG_ISTRIDE = 12'h014;
    localparam logic [B_PADDR-1:0] REG_LENGTH0 = 12'h018;  // Chunks per row minus 1
    localparam logic [B_PADDR-1:0] REG_LENGTH1 = 12'h01C;  // Rows minus 1
    localparam logic [B_PADDR-1:0] REG_MSBIDX  = 12'h020;
    localparam logic [B_PADDR-1:0] DMEM_BASE   = 12'h400;  // Data memory window
    localparam logic [B_PADDR-1:0] WMEM_BASE   = 12'h800;  // Weight memory window

    typedef logic [B_MEMA-1:0]       mem_addr_t;
    typedef logic [B_WORD-1:0]       word_t;
    typedef logic signed [B_ACC-1:0] acc_t;
    typedef logic [B_LEN-1:0]        len_t;
    typedef logic [B_MSBIDX-1:0]     msbidx_t;

    typedef struct packed {
        mem_addr_t ibase;       // First input chunk
        mem_addr_t wbase;       // First weight chunk
        mem_addr_t obase;       // First output word
        mem_addr_t istride;     // Input step between chunks
        len_t      length0;     // Chunks per row minus 1
        len_t      length1;     // Rows minus 1
        msbidx_t   msbidx;      // Quantizer MSB position
    } job_cfg_t;

    typedef struct packed {
        logic      en;
        logic      we;
        mem_addr_t addr;
        word_t     wdata;
    } host_mem_req_t;

    typedef struct packed {
        logic valid;
        logic row_last;         // Last chunk of a row
        logic job_last;         // Last chunk of the job
    } agu_cmd_t;

    typedef enum logic {IDLE, RUN} agu_state_t;

endpackage

`default_nettype wire

// ==== verilog/vector_memory.sv ====
// ======================================================================
// Vector word memory
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

module vector_memory #(
    parameter int MEM_DEPTH_LOG2 = mvu_pkg::B_MEMA
) (
    input  logic                      clk,
    input  mvu_pkg::mem_addr_t        rd_addr,
    output mvu_pkg::word_t            rd_data,
    input  logic                      wr_en,
    input  mvu_pkg::mem_addr_t        wr_addr,
    input  mvu_pkg::word_t            wr_data,
    input  mvu_pkg::host_mem_req_t    host,
    output mvu_pkg::word_t            host_rdata
);

    mvu_pkg::word_t mem [2**MEM_DEPTH_LOG2];

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr[MEM_DEPTH_LOG2-1:0]];               // Engine read, 1 cycle
        if (host.en) host_rdata <= mem[host.addr[MEM_DEPTH_LOG2-1:0]];
        if (wr_en) begin
            mem[wr_addr[MEM_DEPTH_LOG2-1:0]] <= wr_data;             // Engine write has priority
        end else if (host.en && host.we) begin
            mem[host.addr[MEM_DEPTH_LOG2-1:0]] <= host.wdata;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mvu_regs.sv ====
// ======================================================================
// MVU APB register block
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

module mvu_regs (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [mvu_pkg::B_PADDR-1:0]   paddr,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  mvu_pkg::word_t                pwdata,
    output mvu_pkg::word_t                prdata,
    output logic                          pready,
    output logic                          pslverr,
    input  logic                          busy,
    input  logic                          done,
    input  logic                          irq_pending,
    input  mvu_pkg::word_t                dmem_rdata,
    input  mvu_pkg::word_t                wmem_rdata,
    output mvu_pkg::job_cfg_t             cfg,
    output logic                          irq_en,
    output logic                          start,
    output logic                          irq_clr,
    output mvu_pkg::host_mem_req_t        dmem_req,
    output mvu_pkg::host_mem_req_t        wmem_req
);

    logic access;           // APB access phase
    logic is_dmem;
    logic is_wmem;
    logic is_reg;
    logic win_ok;           // Window access allowed, engine idle
    logic rd_wait;          // Wait state of a window read has passed
    logic mem_rd_first;     // First access cycle of a window read
    logic reg_wr;

    assign access  = psel & penable;
    assign is_dmem = paddr[11:10] == mvu_pkg::DMEM_BASE[11:10];
    assign is_wmem = paddr[11:10] == mvu_pkg::WMEM_BASE[11:10];
    assign is_reg  = paddr <= mvu_pkg::REG_MSBIDX;
    assign win_ok  = (is_dmem | is_wmem) & ~busy;

    assign mem_rd_first = access & win_ok & ~pwrite & ~rd_wait;
    assign pready       = ~mem_rd_first;                    // One wait state on window reads
    assign pslverr      = access & (((is_dmem | is_wmem) & busy) |
                                    (~is_dmem & ~is_wmem & ~is_reg));
    assign reg_wr       = access & pwrite & is_reg;

    // Host requests to both memories, shared address and data
    always_comb begin
        dmem_req       = '0;
        dmem_req.we    = pwrite;
        dmem_req.addr  = paddr[mvu_pkg::B_MEMA+1:2];          // Word address
        dmem_req.wdata = pwdata;
        wmem_req       = dmem_req;
        dmem_req.en    = access & win_ok & is_dmem & (pwrite | ~rd_wait);
        wmem_req.en    = access & win_ok & is_wmem & (pwrite | ~rd_wait);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_wait <= 1'b0;
            cfg     <= '0;
            irq_en  <= 1'b0;
            start   <= 1'b0;
            irq_clr <= 1'b0;
        end else begin
            rd_wait <= mem_rd_first;                         // Held for one cycle only
            start   <= reg_wr && paddr == mvu_pkg::REG_CTRL && pwdata[0];
            irq_clr <= reg_wr && paddr == mvu_pkg::REG_STATUS && pwdata[2];
            if (reg_wr) begin
                case (paddr)
                    mvu_pkg::REG_CTRL:    irq_en      <= pwdata[1];
                    mvu_pkg::REG_IBASE:   cfg.ibase   <= mvu_pkg::mem_addr_t'(pwdata);
                    mvu_pkg::REG_WBASE:   cfg.wbase   <= mvu_pkg::mem_addr_t'(pwdata);
                    mvu_pkg::REG_OBASE:   cfg.obase   <= mvu_pkg::mem_addr_t'(pwdata);
                    mvu_pkg::REG_ISTRIDE: cfg.istride <= mvu_pkg::mem_addr_t'(pwdata);
                    mvu_pkg::REG_LENGTH0: cfg.length0 <= mvu_pkg::len_t'(pwdata);
                    mvu_pkg::REG_LENGTH1: cfg.length1 <= mvu_pkg::len_t'(pwdata);
                    mvu_pkg::REG_MSBIDX:  cfg.msbidx  <= mvu_pkg::msbidx_t'(pwdata);
                    default: ;                               // STATUS holds no stored bits
                endcase
            end
        end
    end

    // Read data mux, window words come straight from the memories
    always_comb begin
        prdata = '0;
        if (is_dmem) prdata = dmem_rdata;
        else if (is_wmem) prdata = wmem_rdata;
        else begin
            case (paddr)
                mvu_pkg::REG_CTRL:    prdata = mvu_pkg::word_t'({irq_en, 1'b0});
                mvu_pkg::REG_STATUS:  prdata = mvu_pkg::word_t'({irq_pending, done, busy});
                mvu_pkg::REG_IBASE:   prdata = mvu_pkg::word_t'(cfg.ibase);
                mvu_pkg::REG_WBASE:   prdata = mvu_pkg::word_t'(cfg.wbase);
                mvu_pkg::REG_OBASE:   prdata = mvu_pkg::word_t'(cfg.obase);
                mvu_pkg::REG_ISTRIDE: prdata = mvu_pkg::word_t'(cfg.istride);
                mvu_pkg::REG_LENGTH0: prdata = mvu_pkg::word_t'(cfg.length0);
                mvu_pkg::REG_LENGTH1: prdata = mvu_pkg::word_t'(cfg.length1);
                mvu_pkg::REG_MSBIDX:  prdata = mvu_pkg::word_t'(cfg.msbidx);
                default:              prdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/job_controller.sv ====
// ======================================================================
// MVU job controller
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

module job_controller (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic irq_en,
    input  logic irq_clr,
    input  logic job_finished,
    output logic launch,
    output logic busy,
    output logic done,
    output logic irq_pending
);

    assign launch = start & ~busy;                  // Start ignored while a job runs

    always_ff @(posedge clk) begin
        if (reset) begin
            busy        <= 1'b0;
            done        <= 1'b0;
            irq_pending <= 1'b0;
        end else begin
            if (launch) begin
                busy <= 1'b1;
                done <= 1'b0;                       // Done clears on the next job
            end else if (job_finished) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
            // Sticky until the host clears it
            if (job_finished && irq_en) irq_pending <= 1'b1;
            else if (irq_clr) irq_pending <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/input_agu.sv ====
// ======================================================================
// Input and weight address generator
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

module input_agu (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  launch,
    input  mvu_pkg::job_cfg_t     cfg,
    output mvu_pkg::mem_addr_t    iaddr,
    output mvu_pkg::mem_addr_t    waddr,
    output mvu_pkg::agu_cmd_t     cmd
);

    mvu_pkg::agu_state_t state;
    mvu_pkg::len_t       chunk;         // Inner loop, chunk in row
    mvu_pkg::len_t       row;           // Outer loop
    mvu_pkg::len_t       next_chunk;
    mvu_pkg::len_t       next_row;

    assign next_chunk = cmd.row_last ? '0 : chunk + 1'b1;
    assign next_row   = cmd.row_last ? row + 1'b1 : row;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mvu_pkg::IDLE;
            chunk <= '0;
            row   <= '0;
            cmd   <= '0;
        end else begin
            case (state)
                mvu_pkg::IDLE: begin
                    if (launch) begin
                        state        <= mvu_pkg::RUN;
                        chunk        <= '0;
                        row          <= '0;
                        cmd.valid    <= 1'b1;
                        cmd.row_last <= cfg.length0 == '0;
                        cmd.job_last <= cfg.length0 == '0 && cfg.length1 == '0;
                    end
                end
                mvu_pkg::RUN: begin
                    if (cmd.job_last) begin
                        state <= mvu_pkg::IDLE;     // Final pair issued
                        cmd   <= '0;
                    end else begin
                        chunk        <= next_chunk;
                        row          <= next_row;
                        cmd.row_last <= next_chunk == cfg.length0;
                        cmd.job_last <= next_chunk == cfg.length0 && next_row == cfg.length1;
                    end
                end
                default: state <= mvu_pkg::IDLE;
            endcase
        end
    end

    // Address registers track the loop counters
    always_ff @(posedge clk) begin
        if (state == mvu_pkg::IDLE) begin
            iaddr <= cfg.ibase;
            waddr <= cfg.wbase;
        end else begin
            iaddr <= cmd.row_last ? cfg.ibase : iaddr + cfg.istride;  // Restart each row
            waddr <= waddr + 1'b1;                                     // One weight word per cycle
        end
    end

endmodule

`default_nettype wire

// ==== verilog/vvp_datapath.sv ====
// ======================================================================
// Vector dot product, quantize and pack
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

module vvp_datapath (
    input  logic                  clk,
    input  logic                  reset,
    input  mvu_pkg::job_cfg_t     cfg,
    input  mvu_pkg::agu_cmd_t     cmd,
    input  mvu_pkg::word_t        iword,
    input  mvu_pkg::word_t        wword,
    output logic                  wr_en,
    output mvu_pkg::mem_addr_t    wr_addr,
    output mvu_pkg::word_t        wr_data,
    output logic                  job_finished
);

    localparam int PIPE_LEN = mvu_pkg::MEM_RD_LATENCY + 2;     // Read, product, tree
    localparam int B_PROD   = 2 * mvu_pkg::B_ELEM;
    localparam int B_SLOT   = $clog2(mvu_pkg::N_LANES);

    mvu_pkg::agu_cmd_t        cmd_pipe [PIPE_LEN];
    mvu_pkg::agu_cmd_t        cmd_q;                           // Aligned with sum_q
    logic signed [B_PROD-1:0] prod [mvu_pkg::N_LANES];
    mvu_pkg::acc_t            sum_c;
    mvu_pkg::acc_t            sum_q;
    mvu_pkg::acc_t            acc;
    mvu_pkg::acc_t            acc_next;
    mvu_pkg::acc_t            shifted;
    mvu_pkg::msbidx_t         shamt;
    logic [mvu_pkg::B_ELEM-1:0] qval;
    logic                     row_first;
    logic [B_SLOT-1:0]        slot;                            // Output lane of next row
    mvu_pkg::word_t           pack;
    mvu_pkg::word_t           pack_c;
    mvu_pkg::mem_addr_t       word_idx;

    assign cmd_q = cmd_pipe[PIPE_LEN-1];

    // Control travels alongside the data
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < PIPE_LEN; s++) cmd_pipe[s] <= '0;
        end else begin
            cmd_pipe[0] <= cmd;
            for (int s = 1; s < PIPE_LEN; s++) cmd_pipe[s] <= cmd_pipe[s-1];
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < mvu_pkg::N_LANES; i++) begin
            prod[i] <= $signed(iword[i*mvu_pkg::B_ELEM +: mvu_pkg::B_ELEM]) *
                       $signed(wword[i*mvu_pkg::B_ELEM +: mvu_pkg::B_ELEM]);
        end
        sum_q <= sum_c;
    end

    always_comb begin
        sum_c = '0;
        for (int i = 0; i < mvu_pkg::N_LANES; i++) sum_c = sum_c + mvu_pkg::acc_t'(prod[i]);
    end

    // Row total, then shift to the 4-bit result window
    always_comb begin
        acc_next = row_first ? sum_q : acc + sum_q;           // Load on first chunk
        // MSB index below 3 keeps the raw sum
        shamt    = (cfg.msbidx < mvu_pkg::msbidx_t'(mvu_pkg::B_ELEM - 1)) ? '0 :
                   cfg.msbidx - mvu_pkg::msbidx_t'(mvu_pkg::B_ELEM - 1);
        shifted  = acc_next >>> shamt;
        if (shifted > 7) qval = 4'h7;                         // Saturate high
        else if (shifted < -8) qval = 4'h8;                   // Saturate low
        else qval = shifted[mvu_pkg::B_ELEM-1:0];
        pack_c = pack;
        pack_c[slot*mvu_pkg::B_ELEM +: mvu_pkg::B_ELEM] = qval;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            row_first    <= 1'b1;
            slot         <= '0;
            pack         <= '0;
            word_idx     <= '0;
            wr_en        <= 1'b0;
            job_finished <= 1'b0;
        end else begin
            wr_en        <= 1'b0;
            job_finished <= cmd_q.valid & cmd_q.job_last;
            if (cmd_q.valid) begin
                acc       <= acc_next;
                row_first <= cmd_q.row_last;
                if (cmd_q.row_last) begin
                    if (slot == B_SLOT'(mvu_pkg::N_LANES - 1) || cmd_q.job_last) begin
                        wr_en    <= 1'b1;                     // Full word or job end
                        wr_data  <= pack_c;
                        wr_addr  <= cfg.obase + word_idx;
                        pack     <= '0;                       // Unused lanes stay zero
                        slot     <= '0;
                        word_idx <= cmd_q.job_last ? '0 : word_idx + 1'b1;
                    end else begin
                        pack <= pack_c;
                        slot <= slot + 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mvu_top.sv ====
// ======================================================================
// MVU top level
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

module mvu_top #(
    parameter int MEM_DEPTH_LOG2 = mvu_pkg::B_MEMA
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [mvu_pkg::B_PADDR-1:0]   paddr,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  mvu_pkg::word_t                pwdata,
    output mvu_pkg::word_t                prdata,
    output logic                          pready,
    output logic                          pslverr,
    output logic                          irq
);

    mvu_pkg::job_cfg_t      cfg;
    mvu_pkg::host_mem_req_t dmem_req, wmem_req;
    mvu_pkg::word_t         dmem_rdata, wmem_rdata;
    mvu_pkg::word_t         iword, wword;               // Engine read data
    mvu_pkg::mem_addr_t     iaddr, waddr;
    mvu_pkg::agu_cmd_t      cmd;
    mvu_pkg::mem_addr_t     wr_addr;
    mvu_pkg::word_t         wr_data;
    logic                   wr_en, job_finished;
    logic                   start, irq_clr, irq_en;
    logic                   launch, busy, done;

    mvu_regs regs_i (
        .clk, .reset, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
        .busy, .done, .irq_pending(irq), .dmem_rdata, .wmem_rdata,
        .cfg, .irq_en, .start, .irq_clr, .dmem_req, .wmem_req
    );

    job_controller ctrl_i (
        .clk, .reset, .start, .irq_en, .irq_clr, .job_finished,
        .launch, .busy, .done, .irq_pending(irq)
    );

    input_agu agu_i (.clk, .reset, .launch, .cfg, .iaddr, .waddr, .cmd);

    vvp_datapath vvp_i (
        .clk, .reset, .cfg, .cmd, .iword, .wword, .wr_en, .wr_addr, .wr_data, .job_finished
    );

    // Data memory, inputs and outputs
    vector_memory #(.MEM_DEPTH_LOG2(MEM_DEPTH_LOG2)) dmem (
        .clk, .rd_addr(iaddr), .rd_data(iword), .wr_en, .wr_addr, .wr_data,
        .host(dmem_req), .host_rdata(dmem_rdata)
    );

    // Weight memory, engine never writes it
    vector_memory #(.MEM_DEPTH_LOG2(MEM_DEPTH_LOG2)) wmem (
        .clk, .rd_addr(waddr), .rd_data(wword), .wr_en(1'b0), .wr_addr('0), .wr_data('0),
        .host(wmem_req), .host_rdata(wmem_rdata)
    );

endmodule

`default_nettype wire

// ==== verification/mvu_tb_apb.svh ====
// ======================================================================
// APB master tasks
// ======================================================================
`ifndef MVU_TB_APB_SVH
`define MVU_TB_APB_SVH

localparam int APB_WAIT_LIMIT = 16;                 // Wait states before a transfer is abandoned

// Driven on rising edges, sampled on falling edges
task automatic apb_transfer(input logic wr, input logic [mvu_pkg::B_PADDR-1:0] addr,
                            input mvu_pkg::word_t wdata, output mvu_pkg::word_t rdata,
                            output logic err, output int waits);
    @(posedge clk);
    psel    <= 1'b1;                                // Setup phase
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;                                // Access phase
    waits = 0;
    @(negedge clk);
    while (!pready) begin
        waits++;
        if (waits > APB_WAIT_LIMIT) begin
            $display("APB transfer to %h never completed", addr);
            fail_run();
        end
        @(negedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;                                // Transfer ends on this edge
    penable <= 1'b0;
endtask

task automatic bus_write(input logic [mvu_pkg::B_PADDR-1:0] addr, input mvu_pkg::word_t data);
    mvu_pkg::word_t rdata;
    logic           err;
    int             waits;
    apb_transfer(1'b1, addr, data, rdata, err, waits);
    assert (!err && waits == 0) else begin
        $display("APB write to %h was refused or stalled", addr);
        fail_run();
    end
endtask

task automatic bus_read(input logic [mvu_pkg::B_PADDR-1:0] addr, output mvu_pkg::word_t data);
    logic err;
    int   waits;
    apb_transfer(1'b0, addr, '0, data, err, waits);
    assert (!err) else begin
        $display("APB read from %h returned an error", addr);
        fail_run();
    end
endtask

// Window read, one wait state expected
task automatic check_window_word(input string name, input logic [mvu_pkg::B_PADDR-1:0] addr,
                                 input mvu_pkg::word_t expected);
    mvu_pkg::word_t rdata;
    logic           err;
    int             waits;
    apb_transfer(1'b0, addr, '0, rdata, err, waits);
    check_value($sformatf("%s at %h", name, addr), expected, rdata);
    check_value($sformatf("%s wait states at %h", name, addr), 32'h1, mvu_pkg::word_t'(waits));
endtask

`endif

// ==== verification/mvu_tb.sv ====
// ======================================================================
// MVU testbench
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

module mvu_tb;

    localparam int POLL_LIMIT = 400;                // STATUS reads before giving up

    logic                        clk;
    logic                        reset;
    logic [mvu_pkg::B_PADDR-1:0] paddr;
    logic                        psel;
    logic                        penable;
    logic                        pwrite;
    mvu_pkg::word_t              pwdata;
    mvu_pkg::word_t              prdata;
    logic                        pready;
    logic                        pslverr;
    logic                        irq;
    int                          seed;
    mvu_pkg::word_t              dmem_model [256];  // Expected data memory contents
    mvu_pkg::word_t              wmem_model [256];  // Expected weight memory contents

    mvu_top mvu_top_i (
        .clk, .reset, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr, .irq
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                     // 20 ns period
    end

    task automatic fail_run();
        $display("Some tests failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_value(input string name, input mvu_pkg::word_t expected,
                               input mvu_pkg::word_t actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            fail_run();
        end
    endtask

    `include "mvu_tb_apb.svh"

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Eight signed 4-bit lane pairs, multiplied and summed
    function automatic int dot_word(input mvu_pkg::word_t a, input mvu_pkg::word_t b);
        int sum;
        sum = 0;
        for (int i = 0; i < 8; i++) begin
            sum += int'($signed(a[i*4 +: 4])) * int'($signed(b[i*4 +: 4]));
        end
        return sum;
    endfunction

    // Bit msb of the row sum becomes the result sign bit
    function automatic logic [3:0] quantize(input int sum, input int msb);
        int q;
        q = sum >>> (msb - 3);
        if (q > 7)
            q = 7;                                  // Clamp high
        else if (q < -8)
            q = -8;                                 // Clamp low
        return q[3:0];
    endfunction

    task automatic run_job(input string name, input int ibase, input int istride,
                           input int l0, input int l1, input int msb, input logic irq_en);
        int             wbase;
        int             obase;
        int             sum;
        int             row;
        int             polls;
        logic           err;
        int             waits;
        mvu_pkg::word_t got;
        mvu_pkg::word_t expected;
        wbase = rand_below(16);
        obase = 128 + rand_below(32);               // Above every input word
        bus_write(mvu_pkg::REG_IBASE, ibase);
        bus_write(mvu_pkg::REG_WBASE, wbase);
        bus_write(mvu_pkg::REG_OBASE, obase);
        bus_write(mvu_pkg::REG_ISTRIDE, istride);
        bus_write(mvu_pkg::REG_LENGTH0, l0);
        bus_write(mvu_pkg::REG_LENGTH1, l1);
        bus_write(mvu_pkg::REG_MSBIDX, msb);
        bus_write(mvu_pkg::REG_CTRL, {30'b0, irq_en, 1'b1});
        // Engine owns the memories while busy
        apb_transfer(1'b1, mvu_pkg::DMEM_BASE + 12'h028, ~dmem_model[10], got, err, waits);
        check_value({name, " busy write error"}, 32'h1, mvu_pkg::word_t'(err));
        polls = 0;
        do begin
            bus_read(mvu_pkg::REG_STATUS, got);
            polls++;
            if (polls > POLL_LIMIT) begin
                $display("Timeout waiting for done of %s", name);
                fail_run();
            end
        end while (!got[1]);
        check_value({name, " STATUS at done"}, {29'b0, irq_en, 2'b10}, got);
        @(negedge clk);
        check_value({name, " irq at done"}, mvu_pkg::word_t'(irq_en), mvu_pkg::word_t'(irq));
        check_window_word({name, " busy write ignored"}, mvu_pkg::DMEM_BASE + 12'h028,
                          dmem_model[10]);
        for (int w = 0; w <= l1 / 8; w++) begin     // Eight rows per output word
            expected = '0;
            for (int j = 0; j < 8; j++) begin
                row = w * 8 + j;
                if (row <= l1) begin
                    sum = 0;
                    for (int k = 0; k <= l0; k++) begin
                        sum += dot_word(dmem_model[(ibase + k * istride) % 256],
                                        wmem_model[(wbase + row * (l0 + 1) + k) % 256]);
                    end
                    expected[j*4 +: 4] = quantize(sum, msb);
                end
            end
            check_window_word($sformatf("%s word %0d", name, w),
                              mvu_pkg::DMEM_BASE + 12'(4 * (obase + w)), expected);
            dmem_model[obase + w] = expected;
        end
    endtask

    initial begin
        mvu_pkg::word_t got;
        mvu_pkg::word_t cfg_val [9];
        logic           err;
        int             waits;
        seed    = 32'h6c87bda6;
        reset   = 1'b1;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        @(negedge clk);
        check_value("irq after reset", '0, mvu_pkg::word_t'(irq));
        for (int a = 0; a <= 32; a += 4) begin      // CTRL through MSBIDX
            bus_read(12'(a), got);
            check_value($sformatf("reset value at %h", a), '0, got);
        end

        bus_write(mvu_pkg::REG_CTRL, 32'h2);        // irq enable, no start
        bus_read(mvu_pkg::REG_CTRL, got);
        check_value("CTRL readback", 32'h2, got);
        for (int a = 8; a <= 32; a += 4) begin
            cfg_val[a/4] = $random(seed) & ((a == 32) ? 32'h1f : 32'hff);
            bus_write(12'(a), cfg_val[a/4]);
        end
        for (int a = 8; a <= 32; a += 4) begin
            bus_read(12'(a), got);
            check_value($sformatf("readback at %h", a), cfg_val[a/4], got);
        end
        apb_transfer(1'b0, 12'h024, '0, got, err, waits);   // Past the register file
        check_value("unmapped register error", 32'h1, mvu_pkg::word_t'(err));
        apb_transfer(1'b0, 12'hC00, '0, got, err, waits);   // Above both windows
        check_value("unmapped window error", 32'h1, mvu_pkg::word_t'(err));

        for (int a = 0; a < 256; a++) begin
            dmem_model[a] = $random(seed);
            wmem_model[a] = $random(seed);
            bus_write(mvu_pkg::DMEM_BASE + 12'(4 * a), dmem_model[a]);
            bus_write(mvu_pkg::WMEM_BASE + 12'(4 * a), wmem_model[a]);
        end
        for (int a = 0; a < 256; a++) begin
            check_window_word("data window", mvu_pkg::DMEM_BASE + 12'(4 * a), dmem_model[a]);
            check_window_word("weight window", mvu_pkg::WMEM_BASE + 12'(4 * a), wmem_model[a]);
        end

        run_job("job with irq", rand_below(32), 1 + rand_below(3), rand_below(8),
                8 + rand_below(12), 3 + rand_below(10), 1'b1);
        @(negedge clk);
        check_value("irq held until cleared", 32'h1, mvu_pkg::word_t'(irq));
        bus_write(mvu_pkg::REG_STATUS, 32'h4);      // Clear pending irq
        bus_read(mvu_pkg::REG_STATUS, got);
        check_value("STATUS after irq clear", 32'h2, got);
        @(negedge clk);
        check_value("irq after clear", '0, mvu_pkg::word_t'(irq));

        // Same input chunk for every step of a row
        run_job("job with stride 0", rand_below(32), 0, rand_below(8), rand_below(20),
                3 + rand_below(10), 1'b0);

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+verification
verilog/mvu_pkg.sv
verilog/vector_memory.sv
verilog/mvu_regs.sv
verilog/job_controller.sv
verilog/input_agu.sv
verilog/vvp_datapath.sv
verilog/mvu_top.sv
verification/mvu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the MVU testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module mvu_tb -o mvu_sim
./obj_dir/mvu_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "All tests passed" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
